// File: common/up_pkg.sv
`default_nettype none

package up_pkg;

   // datapath word, one byte wide
   typedef logic [7:0] word_t;

   // register block address, four general registers
   typedef logic [1:0] reg_addr_t;

   // one nibble of a fetched instruction byte
   typedef logic [3:0] instr_t;

   // alu operation code
   typedef logic [2:0] alu_op_t;

   // number of general registers
   localparam int NUM_REGS = 4;

   // alu operations
   localparam alu_op_t ALU_ADD = 3'd0;
   localparam alu_op_t ALU_SUB = 3'd1;
   localparam alu_op_t ALU_AND = 3'd2;
   localparam alu_op_t ALU_OR  = 3'd3;
   localparam alu_op_t ALU_XOR = 3'd4;
   localparam alu_op_t ALU_NOT = 3'd5;
   localparam alu_op_t ALU_INC = 3'd6;
   localparam alu_op_t ALU_DEC = 3'd7;

   // program counter starts at the bottom of memory
   localparam word_t PC_RESET = 8'h00;

   // stack grows down from the top
   localparam word_t SP_RESET = 8'hFF;

endpackage

`default_nettype wire

// File: common/up_rb_if.sv
`timescale 1ns/1ps
`default_nettype none

interface up_rb_if
   import up_pkg::*;
();

   // read side
   reg_addr_t sel_out_a;
   reg_addr_t sel_out_b;
   word_t     rdata_a;
   word_t     rdata_b;

   // write side
   reg_addr_t sel_in;
   logic      we;
   word_t     wdata;

   modport ctrl (
      output sel_out_a,
      output sel_out_b,
      output sel_in,
      output we,
      output wdata,
      input  rdata_a,
      input  rdata_b
   );

   modport regs (
      input  sel_out_a,
      input  sel_out_b,
      input  sel_in,
      input  we,
      input  wdata,
      output rdata_a,
      output rdata_b
   );

endinterface

`default_nettype wire

// File: source/up_alu.sv
`timescale 1ns/1ps
`default_nettype none

module up_alu
   import up_pkg::*;
(
   input  word_t   pc_val,
   input  word_t   sp_val,
   input  word_t   rdata_a,
   input  word_t   rdata_b,
   input  logic    sel_in_a,
   input  logic    sel_in_b,
   input  alu_op_t op,
   output word_t   result
);

   word_t opnd_a;
   word_t opnd_b;

   // operand a is the pc when stepping it, else register port a
   always_comb begin
      if (sel_in_a) begin
         opnd_a = pc_val;
      end else begin
         opnd_a = rdata_a;
      end
   end

   // operand b is the sp when stepping it, else register port b
   always_comb begin
      if (sel_in_b) begin
         opnd_b = sp_val;
      end else begin
         opnd_b = rdata_b;
      end
   end

   // all results wrap at 8 bits
   always_comb begin
      case (op)
         ALU_ADD: begin
            result = opnd_a + opnd_b;
         end
         ALU_SUB: begin
            result = opnd_a - opnd_b;
         end
         ALU_AND: begin
            result = opnd_a & opnd_b;
         end
         ALU_OR: begin
            result = opnd_a | opnd_b;
         end
         ALU_XOR: begin
            result = opnd_a ^ opnd_b;
         end
         ALU_NOT: begin
            result = ~opnd_a;
         end
         ALU_INC: begin
            result = opnd_a + 8'd1;
         end
         ALU_DEC: begin
            result = opnd_a - 8'd1;
         end
         default: begin
            result = '0;
         end
      endcase
   end

   // the control unit must always present a defined opcode,
   // otherwise data_out and every register it feeds go unknown
   always_comb begin
      assert (!$isunknown(op))
         else $error("alu opcode has unknown bits");
   end

endmodule

`default_nettype wire

// File: source/up_reg_block.sv
`timescale 1ns/1ps
`default_nettype none

module up_reg_block
   import up_pkg::*;
(
   input  logic     clk,
   input  logic     nRst,
   up_rb_if.regs    rb
);

   word_t regs [NUM_REGS];

   // single write port
   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else begin
         if (rb.we) begin
            regs[rb.sel_in] <= rb.wdata;
         end
      end
   end

   // read ports see the old value until the write edge
   always_comb begin
      rb.rdata_a = regs[rb.sel_out_a];
   end

   always_comb begin
      rb.rdata_b = regs[rb.sel_out_b];
   end

   // the write address comes from the datapath strobes
   a_sel_in_known: assert property (
      @(posedge clk) disable iff (!nRst)
      rb.we |-> !$isunknown(rb.sel_in)
   ) else $error("register write with unknown address");

endmodule

`default_nettype wire

// File: source/up_instruction_register.sv
`timescale 1ns/1ps
`default_nettype none

module up_instruction_register
   import up_pkg::*;
(
   input  logic   clk,
   input  logic   nRst,
   input  logic   we,
   input  logic   nibble_sel,
   input  word_t  fetch,
   output instr_t ir
);

   instr_t nibble;

   // odd address holds the high nibble
   always_comb begin
      if (nibble_sel) begin
         nibble = fetch[7:4];
      end else begin
         nibble = fetch[3:0];
      end
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         ir <= '0;
      end else if (we) begin
         ir <= nibble;
      end
   end

   a_ir_hold: assert property (
      @(posedge clk) disable iff (!nRst)
      !we |=> $stable(ir)
   ) else $error("instruction register changed without a load");

endmodule

`default_nettype wire

// File: up_datapath/up_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module up_datapath
   import up_pkg::*;
(
   input  logic      clk,
   input  logic      nRst,
   input  word_t     data_in,
   input  logic      rb_sel_data_in,
   // alu control
   input  logic      a_sel_in_a,
   input  logic      a_sel_in_b,
   input  alu_op_t   a_op,
   // instruction register
   input  logic      ir_we,
   // program counter
   input  logic      pc_we,
   // register block
   input  reg_addr_t rb_sel_out_a,
   input  reg_addr_t rb_sel_out_b,
   input  reg_addr_t rb_sel_in,
   input  logic      rb_we,
   // stack pointer
   input  logic      sp_we,
   output word_t     data_out,
   output instr_t    ir
);

   word_t pc;
   word_t sp;
   word_t alu_result;

   up_rb_if rb_bus ();

   // pc and sp both load from the alu result
   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         pc <= PC_RESET;
      end else if (pc_we) begin
         pc <= alu_result;
      end
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         sp <= SP_RESET;
      end else if (sp_we) begin
         sp <= alu_result;
      end
   end

   assign data_out = alu_result;

   // register block control straight from the strobes
   assign rb_bus.sel_out_a = rb_sel_out_a;
   assign rb_bus.sel_out_b = rb_sel_out_b;
   assign rb_bus.sel_in    = rb_sel_in;
   assign rb_bus.we        = rb_we;

   // write data is either the external bus or the alu
   always_comb begin
      if (rb_sel_data_in) begin
         rb_bus.wdata = data_in;
      end else begin
         rb_bus.wdata = alu_result;
      end
   end

   up_reg_block u_reg_block (
      .clk      (clk),
      .nRst     (nRst),
      .rb       (rb_bus.regs)
   );

   up_alu u_alu (
      .pc_val   (pc),
      .sp_val   (sp),
      .rdata_a  (rb_bus.rdata_a),
      .rdata_b  (rb_bus.rdata_b),
      .sel_in_a (a_sel_in_a),
      .sel_in_b (a_sel_in_b),
      .op       (a_op),
      .result   (alu_result)
   );

   // pc bit 0 picks which half of the fetched byte is the opcode
   up_instruction_register u_instruction_register (
      .clk        (clk),
      .nRst       (nRst),
      .we         (ir_we),
      .nibble_sel (pc[0]),
      .fetch      (data_in),
      .ir         (ir)
   );

   // write strobes from the control unit are levels and must be defined
   a_strobes_known: assert property (
      @(posedge clk) disable iff (!nRst)
      !$isunknown({pc_we, sp_we, ir_we, rb_we})
   ) else $error("write strobe has unknown bits");

endmodule

`default_nettype wire

// File: dv/up_datapath_tb.sv
`timescale 1ns/1ps
`default_nettype none

module up_datapath_tb
   import up_pkg::*;
();

   localparam int CLK_PERIOD    = 10;
   localparam int RESET_CYCLES  = 4;
   localparam int RESET_TIMEOUT = 20;
   localparam int RANDOM_CYCLES = 2000;
   localparam int SEED          = 2542;

   logic      clk;
   logic      nRst;
   word_t     data_in;
   logic      rb_sel_data_in;
   logic      a_sel_in_a;
   logic      a_sel_in_b;
   alu_op_t   a_op;
   logic      ir_we;
   logic      pc_we;
   reg_addr_t rb_sel_out_a;
   reg_addr_t rb_sel_out_b;
   reg_addr_t rb_sel_in;
   logic      rb_we;
   logic      sp_we;
   word_t     data_out;
   instr_t    ir;

   // shadow state of the datapath
   word_t  model_regs [4];
   word_t  model_pc;
   word_t  model_sp;
   instr_t model_ir;

   string test_name;
   int    error_count;

   up_datapath UUT (
      .clk            (clk),
      .nRst           (nRst),
      .data_in        (data_in),
      .rb_sel_data_in (rb_sel_data_in),
      .a_sel_in_a     (a_sel_in_a),
      .a_sel_in_b     (a_sel_in_b),
      .a_op           (a_op),
      .ir_we          (ir_we),
      .pc_we          (pc_we),
      .rb_sel_out_a   (rb_sel_out_a),
      .rb_sel_out_b   (rb_sel_out_b),
      .rb_sel_in      (rb_sel_in),
      .rb_we          (rb_we),
      .sp_we          (sp_we),
      .data_out       (data_out),
      .ir             (ir)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // opcode table, 8-bit wraparound
   function automatic word_t alu_ref(input alu_op_t op, input word_t a, input word_t b);
      word_t res;
      case (op)
         ALU_ADD: res = a + b;
         ALU_SUB: res = a - b;
         ALU_AND: res = a & b;
         ALU_OR:  res = a | b;
         ALU_XOR: res = a ^ b;
         ALU_NOT: res = ~a;
         ALU_INC: res = a + 8'd1;
         default: res = a - 8'd1;
      endcase
      return res;
   endfunction

   // expected data_out for the current strobes, then the shadow state after the edge
   function automatic word_t model_cycle();
      word_t opnd_a;
      word_t opnd_b;
      word_t dout;
      opnd_a = a_sel_in_a ? model_pc : model_regs[rb_sel_out_a];
      opnd_b = a_sel_in_b ? model_sp : model_regs[rb_sel_out_b];
      dout = alu_ref(a_op, opnd_a, opnd_b);
      // ir uses the pc from before the edge
      if (ir_we) begin
         model_ir = model_pc[0] ? data_in[7:4] : data_in[3:0];
      end
      if (rb_we) begin
         model_regs[rb_sel_in] = rb_sel_data_in ? data_in : dout;
      end
      if (pc_we) begin
         model_pc = dout;
      end
      if (sp_we) begin
         model_sp = dout;
      end
      return dout;
   endfunction

   task automatic check_value(input string name, input word_t expected, input word_t actual);
      if (actual !== expected) begin
         error_count++;
         $display("[FAIL] %s expected 0x%02h actual 0x%02h", name, expected, actual);
         $display("test failed");
         $fatal(1, "value mismatch in %s", name);
      end
   endtask

   task automatic drive(input string name, input alu_op_t op, input logic sa, input logic sb,
                        input reg_addr_t ra, input reg_addr_t rbb, input reg_addr_t rin,
                        input logic rwe, input logic rsel, input word_t din,
                        input logic pcwe, input logic spwe, input logic irwe);
      @(negedge clk);
      test_name      = name;
      a_op           = op;
      a_sel_in_a     = sa;
      a_sel_in_b     = sb;
      rb_sel_out_a   = ra;
      rb_sel_out_b   = rbb;
      rb_sel_in      = rin;
      rb_we          = rwe;
      rb_sel_data_in = rsel;
      data_in        = din;
      pc_we          = pcwe;
      sp_we          = spwe;
      ir_we          = irwe;
   endtask

   task automatic read_alu(input string name, input alu_op_t op, input logic sa,
                           input logic sb, input reg_addr_t ra, input reg_addr_t rbb);
      drive(name, op, sa, sb, ra, rbb, 2'd0, 1'b0, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0);
   endtask

   task automatic load_reg(input string name, input reg_addr_t r, input word_t value);
      drive(name, ALU_ADD, 1'b0, 1'b0, 2'd0, 2'd0, r, 1'b1, 1'b1, value, 1'b0, 1'b0, 1'b0);
   endtask

   // copy register r into pc or sp through an or with itself
   task automatic set_pc(input string name, input reg_addr_t r);
      drive(name, ALU_OR, 1'b0, 1'b0, r, r, 2'd0, 1'b0, 1'b0, 8'h00, 1'b1, 1'b0, 1'b0);
   endtask

   task automatic set_sp(input string name, input reg_addr_t r);
      drive(name, ALU_OR, 1'b0, 1'b0, r, r, 2'd0, 1'b0, 1'b0, 8'h00, 1'b0, 1'b1, 1'b0);
   endtask

   task automatic step_pc(input string name, input alu_op_t op);
      drive(name, op, 1'b1, 1'b0, 2'd0, 2'd0, 2'd0, 1'b0, 1'b0, 8'h00, 1'b1, 1'b0, 1'b0);
   endtask

   // sp and its mirror in register 2 step together
   task automatic step_sp(input string name, input alu_op_t op);
      drive(name, op, 1'b0, 1'b0, 2'd2, 2'd0, 2'd2, 1'b1, 1'b0, 8'h00, 1'b0, 1'b1, 1'b0);
   endtask

   task automatic load_ir(input string name, input logic irwe);
      logic [31:0] rnd;
      rnd = $urandom();
      drive(name, ALU_ADD, 1'b0, 1'b0, 2'd0, 2'd0, 2'd0, 1'b0, 1'b0, rnd[7:0], 1'b0, 1'b0, irwe);
   endtask

   task automatic random_cycle();
      logic [31:0] r0;
      logic [31:0] r1;
      r0 = $urandom();
      r1 = $urandom();
      drive("random_mix", r0[2:0], r0[3], r0[4], r0[6:5], r0[8:7], r0[10:9], r0[11],
            r0[12], r1[7:0], r0[13], r0[14], r0[15]);
   endtask

   // compare process, data_out late in the cycle and ir just after the edge
   initial begin : compare
      int    wait_cycles;
      word_t expected;
      wait_cycles = 0;
      while (nRst !== 1'b1) begin
         @(negedge clk);
         #1;
         wait_cycles++;
         if (wait_cycles > RESET_TIMEOUT) begin
            $display("reset was never released");
            $display("test failed");
            $fatal(1, "timeout waiting for reset release");
         end
      end
      forever begin
         @(negedge clk);
         #4;
         expected = model_cycle();
         check_value(test_name, expected, data_out);
         @(posedge clk);
         #1;
         check_value($sformatf("%s ir", test_name), {4'h0, model_ir}, {4'h0, ir});
      end
   end

   initial begin : stimulus
      logic [31:0] rnd;
      void'($urandom(SEED));
      error_count    = 0;
      test_name      = "reset";
      nRst           = 1'b0;
      data_in        = 8'h00;
      rb_sel_data_in = 1'b0;
      a_sel_in_a     = 1'b0;
      a_sel_in_b     = 1'b0;
      a_op           = ALU_ADD;
      ir_we          = 1'b0;
      pc_we          = 1'b0;
      rb_sel_out_a   = 2'd0;
      rb_sel_out_b   = 2'd0;
      rb_sel_in      = 2'd0;
      rb_we          = 1'b0;
      sp_we          = 1'b0;
      // reset values
      for (int r = 0; r < 4; r++) begin
         model_regs[r] = 8'h00;
      end
      model_pc = 8'h00;
      model_sp = 8'hFF;
      model_ir = 4'h0;
      repeat (RESET_CYCLES) @(negedge clk);
      nRst = 1'b1;

      read_alu("reset_pc", ALU_ADD, 1'b1, 1'b0, 2'd0, 2'd0);
      read_alu("reset_sp", ALU_ADD, 1'b0, 1'b1, 2'd0, 2'd0);

      for (int r = 0; r < 4; r++) begin
         rnd = $urandom();
         load_reg("alu_load", r[1:0], rnd[7:0]);
      end
      for (int i = 0; i < 8; i++) begin
         repeat (6) begin
            rnd = $urandom();
            read_alu($sformatf("alu_op_%0d", i), i[2:0], 1'b0, 1'b0, rnd[1:0], rnd[3:2]);
         end
      end

      rnd = $urandom();
      load_reg("reg_from_data_in", 2'd1, rnd[7:0]);
      read_alu("reg_from_data_in_port_a", ALU_NOT, 1'b0, 1'b0, 2'd1, 2'd0);
      read_alu("reg_from_data_in_port_b", ALU_ADD, 1'b1, 1'b0, 2'd0, 2'd1);
      rnd = $urandom();
      drive("reg_from_data_out", ALU_XOR, 1'b0, 1'b0, 2'd1, 2'd3, 2'd2, 1'b1, 1'b0,
            rnd[7:0], 1'b0, 1'b0, 1'b0);
      read_alu("reg_from_data_out_port_a", ALU_NOT, 1'b0, 1'b0, 2'd2, 2'd0);
      read_alu("reg_from_data_out_port_b", ALU_ADD, 1'b1, 1'b0, 2'd0, 2'd2);

      // pc from 0xfe up through the wrap and back
      load_reg("pc_wrap", 2'd0, 8'h00);
      load_reg("pc_wrap", 2'd3, 8'hFE);
      set_pc("pc_wrap", 2'd3);
      step_pc("pc_inc", ALU_INC);
      step_pc("pc_inc_wrap", ALU_INC);
      step_pc("pc_dec_wrap", ALU_DEC);
      read_alu("pc_read", ALU_ADD, 1'b1, 1'b0, 2'd0, 2'd0);

      load_reg("sp_wrap", 2'd2, 8'h01);
      set_sp("sp_wrap", 2'd2);
      step_sp("sp_dec", ALU_DEC);
      step_sp("sp_dec_wrap", ALU_DEC);
      read_alu("sp_read", ALU_ADD, 1'b0, 1'b1, 2'd0, 2'd0);
      step_sp("sp_inc_wrap", ALU_INC);
      step_sp("sp_inc", ALU_INC);
      read_alu("sp_read", ALU_ADD, 1'b0, 1'b1, 2'd0, 2'd0);

      // even pc takes the low nibble, odd pc the high one
      load_reg("ir_nibble", 2'd3, 8'h10);
      set_pc("ir_nibble", 2'd3);
      load_ir("ir_even", 1'b1);
      repeat (3) load_ir("ir_hold_even", 1'b0);
      step_pc("ir_nibble", ALU_INC);
      load_ir("ir_odd", 1'b1);
      repeat (3) load_ir("ir_hold_odd", 1'b0);

      repeat (RANDOM_CYCLES) random_cycle();

      read_alu("idle", ALU_ADD, 1'b0, 1'b0, 2'd0, 2'd0);
      read_alu("idle", ALU_ADD, 1'b0, 1'b0, 2'd0, 2'd0);

      if (error_count == 0) begin
         $display("test passed");
         $finish;
      end else begin
         $display("test failed");
         $fatal(1, "%0d checks did not match", error_count);
      end
   end

endmodule

`default_nettype wire

// File: up_datapath.f
common/up_pkg.sv
common/up_rb_if.sv
source/up_alu.sv
source/up_reg_block.sv
source/up_instruction_register.sv
up_datapath/up_datapath.sv
dv/up_datapath_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the up_datapath testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=up_datapath_sim
LOG_FILE=sim.log

verilator --binary --timing --assert -j 0 \
   --top-module up_datapath_tb \
   -f up_datapath.f \
   --Mdir "$BUILD_DIR" \
   -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"

if grep -q "test failed" "$LOG_FILE"; then
   echo "simulation reported a failure"
   exit 1
fi

if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

echo "simulation finished cleanly"
exit 0
